// ==== hdl/rv32_pkg.sv ====
package rv32_pkg;

  localparam int xlen_lp = 32;
  localparam int bus_w_lp = 16;
  localparam int reg_aw_lp = 5;
  localparam int ucode_aw_lp = 5;
  localparam logic [xlen_lp-1:0] reset_vector_lp = 32'h0000_0000;
  // two halfword fetch steps precede every execute sequence
  localparam logic [ucode_aw_lp-1:0] fetch_steps_lp = 5'd2;

  // major opcode, instruction bits 6..2
  typedef enum logic [4:0] {
    op_load   = 5'b00000,
    op_fence  = 5'b00011,
    op_alui   = 5'b00100,
    op_auipc  = 5'b00101,
    op_store  = 5'b01000,
    op_alu    = 5'b01100,
    op_lui    = 5'b01101,
    op_branch = 5'b11000,
    op_jalr   = 5'b11001,
    op_jal    = 5'b11011,
    op_system = 5'b11100
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and
  } alu_op_e;

  typedef enum logic [2:0] {
    addr_pc, addr_pc_hi, addr_load, addr_load_hi, addr_store, addr_store_hi
  } addr_sel_e;

  typedef enum logic [1:0] {wb_alu, wb_upper_imm, wb_load, wb_link} wb_sel_e;

  typedef enum logic [1:0] {pc_plus4, pc_jal, pc_jalr, pc_branch} pc_sel_e;

  // microcode table entries, one per execute step of each class
  typedef enum logic [ucode_aw_lp-1:0] {
    uc_fetch_lo = 5'd0,
    uc_fetch_hi = 5'd1,
    uc_alu      = 5'd2,
    uc_alui     = 5'd3,
    uc_lui      = 5'd4,
    uc_auipc    = 5'd5,
    uc_jal      = 5'd6,
    uc_jalr     = 5'd7,
    uc_branch   = 5'd8,
    uc_fence    = 5'd9,
    uc_load_lo  = 5'd10,
    uc_load_hi  = 5'd11,
    uc_store_lo = 5'd12,
    uc_store_hi = 5'd13,
    uc_ebreak   = 5'd14,
    uc_illegal  = 5'd31
  } ucode_addr_e;

  typedef struct packed {
    addr_sel_e addr_sel;
    logic      ir_lo_we;
    logic      ir_hi_we;
    logic      load_lo_we;
    logic      mem_we;
    logic      store_hi;
    logic      op2_imm;
    logic      auipc_add;
    wb_sel_e   wb_sel;
    logic      rd_we;
    pc_sel_e   pc_sel;
    logic      pc_we;
    logic      cond_pc;
    logic      halt;
    logic      seq_end;
  } ctrl_word_t;

endpackage

// ==== hdl/rv32_if.sv ====
interface reg_if import rv32_pkg::*; ();
  logic [reg_aw_lp-1:0] rs1_addr;
  logic [reg_aw_lp-1:0] rs2_addr;
  logic [reg_aw_lp-1:0] rd_addr;
  logic                 rd_we;
  logic [xlen_lp-1:0]   rd_data;
  logic [xlen_lp-1:0]   rs1_data;
  logic [xlen_lp-1:0]   rs2_data;

  modport ctrl (
    output rs1_addr, rs2_addr, rd_addr, rd_we, rd_data,
    input  rs1_data, rs2_data
  );
  modport regs (
    input  rs1_addr, rs2_addr, rd_addr, rd_we, rd_data,
    output rs1_data, rs2_data
  );
endinterface

interface alu_if import rv32_pkg::*; ();
  alu_op_e            op;
  logic [xlen_lp-1:0] a;
  logic [xlen_lp-1:0] b;
  logic [xlen_lp-1:0] result;
  // comparison flags for branches
  logic               eq;
  logic               lt;
  logic               ltu;

  modport ctrl (output op, a, b, input result, eq, lt, ltu);
  modport alu (input op, a, b, output result, eq, lt, ltu);
endinterface

// ==== hdl/rv32_microcode.sv ====
module rv32_microcode import rv32_pkg::*; (
  input  logic [ucode_aw_lp-1:0] ucode_addr_i,
  output ctrl_word_t             ctrl_o
);

  always_comb begin
    ctrl_o = '0;
    case (ucode_addr_i)
      uc_fetch_lo: begin
        ctrl_o.addr_sel = addr_pc;
        ctrl_o.ir_lo_we = 1'b1;
      end
      uc_fetch_hi: begin
        ctrl_o.addr_sel = addr_pc_hi;
        ctrl_o.ir_hi_we = 1'b1;
      end
      uc_alu, uc_alui: begin
        ctrl_o.op2_imm = (ucode_addr_i == uc_alui);
        ctrl_o.wb_sel  = wb_alu;
        ctrl_o.rd_we   = 1'b1;
        ctrl_o.pc_sel  = pc_plus4;
        ctrl_o.pc_we   = 1'b1;
        ctrl_o.seq_end = 1'b1;
      end
      uc_lui, uc_auipc: begin
        ctrl_o.auipc_add = (ucode_addr_i == uc_auipc);
        ctrl_o.wb_sel    = wb_upper_imm;
        ctrl_o.rd_we     = 1'b1;
        ctrl_o.pc_sel    = pc_plus4;
        ctrl_o.pc_we     = 1'b1;
        ctrl_o.seq_end   = 1'b1;
      end
      uc_jal, uc_jalr: begin
        // link value and jump target land on the same edge
        ctrl_o.op2_imm = (ucode_addr_i == uc_jalr);
        ctrl_o.wb_sel  = wb_link;
        ctrl_o.rd_we   = 1'b1;
        ctrl_o.pc_sel  = (ucode_addr_i == uc_jalr) ? pc_jalr : pc_jal;
        ctrl_o.pc_we   = 1'b1;
        ctrl_o.seq_end = 1'b1;
      end
      uc_branch: begin
        ctrl_o.pc_sel  = pc_branch;
        ctrl_o.cond_pc = 1'b1;
        ctrl_o.pc_we   = 1'b1;
        ctrl_o.seq_end = 1'b1;
      end
      uc_fence: begin
        ctrl_o.pc_sel  = pc_plus4;
        ctrl_o.pc_we   = 1'b1;
        ctrl_o.seq_end = 1'b1;
      end
      uc_load_lo: begin
        ctrl_o.addr_sel   = addr_load;
        ctrl_o.op2_imm    = 1'b1;
        ctrl_o.load_lo_we = 1'b1;
      end
      uc_load_hi: begin
        ctrl_o.addr_sel = addr_load_hi;
        ctrl_o.op2_imm  = 1'b1;
        ctrl_o.wb_sel   = wb_load;
        ctrl_o.rd_we    = 1'b1;
        ctrl_o.pc_we    = 1'b1;
        ctrl_o.seq_end  = 1'b1;
      end
      uc_store_lo: begin
        ctrl_o.addr_sel = addr_store;
        ctrl_o.op2_imm  = 1'b1;
        ctrl_o.mem_we   = 1'b1;
      end
      uc_store_hi: begin
        ctrl_o.addr_sel = addr_store_hi;
        ctrl_o.op2_imm  = 1'b1;
        ctrl_o.mem_we   = 1'b1;
        ctrl_o.store_hi = 1'b1;
        ctrl_o.pc_we    = 1'b1;
        ctrl_o.seq_end  = 1'b1;
      end
      uc_ebreak: ctrl_o.halt = 1'b1;
      // unknown class stops the core
      default: ctrl_o.halt = 1'b1;
    endcase
  end

endmodule

// ==== hdl/rv32_control.sv ====
module rv32_control import rv32_pkg::*; (
  input  logic                   clk_i,
  input  logic                   reset_i,
  output logic [xlen_lp-1:0]     mem_addr_o,
  input  logic [bus_w_lp-1:0]    mem_rdata_i,
  output logic [bus_w_lp-1:0]    mem_wdata_o,
  output logic                   mem_we_o,
  output logic                   halt_o,
  output logic [ucode_aw_lp-1:0] ucode_addr_o,
  input  ctrl_word_t             ctrl_i,
  reg_if.ctrl                    regs,
  alu_if.ctrl                    alu
);

  logic [ucode_aw_lp-1:0] step_q;
  logic [ucode_aw_lp-1:0] offset_q;
  ucode_addr_e            class_base;
  logic [xlen_lp-1:0]     ir_q;
  logic [xlen_lp-1:0]     pc_q;
  logic [xlen_lp-1:0]     pc_next;
  logic [bus_w_lp-1:0]    load_lo_q;
  logic                   halt_q;
  logic                   taken;
  opcode_e                opc;
  alu_op_e                alu_op_d;
  logic [xlen_lp-1:0]     imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [xlen_lp-1:0]     mem_addr_d;

  assign opc   = opcode_e'(ir_q[6:2]);
  assign imm_i = {{20{ir_q[31]}}, ir_q[31:20]};
  assign imm_s = {{20{ir_q[31]}}, ir_q[31:25], ir_q[11:7]};
  assign imm_b = {{19{ir_q[31]}}, ir_q[31], ir_q[7], ir_q[30:25], ir_q[11:8], 1'b0};
  assign imm_u = {ir_q[31:12], 12'b0};
  assign imm_j = {{11{ir_q[31]}}, ir_q[31], ir_q[19:12], ir_q[20], ir_q[30:21], 1'b0};

  // step counter, frozen once a halt word is reached
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      step_q <= '0;
    end else if (ctrl_i.seq_end) begin
      step_q <= '0;
    end else if (!ctrl_i.halt) begin
      step_q <= step_q + 1'b1;
    end
  end

  assign ucode_addr_o = (step_q < fetch_steps_lp) ? step_q : step_q + offset_q;

  // class entry point, decoded from the low half as it arrives
  always_comb begin
    case (opcode_e'(mem_rdata_i[6:2]))
      op_load:   class_base = uc_load_lo;
      op_fence:  class_base = uc_fence;
      op_alui:   class_base = uc_alui;
      op_auipc:  class_base = uc_auipc;
      op_store:  class_base = uc_store_lo;
      op_alu:    class_base = uc_alu;
      op_lui:    class_base = uc_lui;
      op_branch: class_base = uc_branch;
      op_jalr:   class_base = uc_jalr;
      op_jal:    class_base = uc_jal;
      op_system: class_base = uc_ebreak;
      default:   class_base = uc_illegal;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      offset_q <= '0;
      halt_q   <= 1'b0;
      pc_q     <= reset_vector_lp;
    end else begin
      if (ctrl_i.ir_lo_we) offset_q <= class_base - fetch_steps_lp;
      if (ctrl_i.halt) halt_q <= 1'b1;
      if (ctrl_i.pc_we) pc_q <= pc_next;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ctrl_i.ir_lo_we) ir_q[15:0] <= mem_rdata_i;
    if (ctrl_i.ir_hi_we) ir_q[31:16] <= mem_rdata_i;
    if (ctrl_i.load_lo_we) load_lo_q <= mem_rdata_i;
  end

  // shared funct3 decode for register and immediate forms
  always_comb begin
    alu_op_d = alu_add;
    if (opc == op_alu || opc == op_alui) begin
      case (ir_q[14:12])
        3'b000: alu_op_d = (opc == op_alu && ir_q[30]) ? alu_sub : alu_add;
        3'b001: alu_op_d = alu_sll;
        3'b010: alu_op_d = alu_slt;
        3'b011: alu_op_d = alu_sltu;
        3'b100: alu_op_d = alu_xor;
        3'b101: alu_op_d = ir_q[30] ? alu_sra : alu_srl;
        3'b110: alu_op_d = alu_or;
        3'b111: alu_op_d = alu_and;
      endcase
    end
  end

  assign regs.rs1_addr = ir_q[19:15];
  assign regs.rs2_addr = ir_q[24:20];
  assign regs.rd_addr  = ir_q[11:7];
  assign regs.rd_we    = ctrl_i.rd_we;

  // the ALU also forms load, store and JALR addresses
  assign alu.op = alu_op_d;
  assign alu.a  = regs.rs1_data;
  assign alu.b  = !ctrl_i.op2_imm ? regs.rs2_data : (opc == op_store) ? imm_s : imm_i;

  always_comb begin
    case (ctrl_i.wb_sel)
      wb_upper_imm: regs.rd_data = ctrl_i.auipc_add ? pc_q + imm_u : imm_u;
      wb_load:      regs.rd_data = {mem_rdata_i, load_lo_q};
      wb_link:      regs.rd_data = pc_q + 32'd4;
      default:      regs.rd_data = alu.result;
    endcase
  end

  always_comb begin
    case (ctrl_i.addr_sel)
      addr_pc_hi:               mem_addr_d = pc_q + 32'd2;
      addr_load, addr_store:    mem_addr_d = alu.result;
      addr_load_hi, addr_store_hi: mem_addr_d = alu.result + 32'd2;
      default:                  mem_addr_d = pc_q;
    endcase
  end

  assign mem_addr_o  = {mem_addr_d[xlen_lp-1:1], 1'b0};
  assign mem_wdata_o = ctrl_i.store_hi ? regs.rs2_data[31:16] : regs.rs2_data[15:0];
  assign mem_we_o    = ctrl_i.mem_we;
  assign halt_o      = halt_q;

  always_comb begin
    case (ir_q[14:12])
      3'b000:  taken = alu.eq;
      3'b001:  taken = !alu.eq;
      3'b100:  taken = alu.lt;
      3'b101:  taken = !alu.lt;
      3'b110:  taken = alu.ltu;
      3'b111:  taken = !alu.ltu;
      default: taken = 1'b0;
    endcase
    taken = taken & ctrl_i.cond_pc;
  end

  // targets are relative to the PC of the current instruction
  always_comb begin
    case (ctrl_i.pc_sel)
      pc_jal:    pc_next = pc_q + imm_j;
      pc_jalr:   pc_next = {alu.result[xlen_lp-1:1], 1'b0};
      pc_branch: pc_next = taken ? pc_q + imm_b : pc_q + 32'd4;
      default:   pc_next = pc_q + 32'd4;
    endcase
  end

endmodule

// ==== hdl/rv32_regfile.sv ====
module rv32_regfile import rv32_pkg::*; (
  input logic clk_i,
  input logic reset_i,
  reg_if.regs regs
);

  // x0 has no storage
  logic [xlen_lp-1:0] rf_q [1:31];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 1; i < 32; i++) begin
        rf_q[i] <= '0;
      end
    end else if (regs.rd_we && regs.rd_addr != '0) begin
      rf_q[regs.rd_addr] <= regs.rd_data;
    end
  end

  assign regs.rs1_data = (regs.rs1_addr == '0) ? '0 : rf_q[regs.rs1_addr];
  assign regs.rs2_data = (regs.rs2_addr == '0) ? '0 : rf_q[regs.rs2_addr];

endmodule

// ==== hdl/rv32_alu.sv ====
module rv32_alu import rv32_pkg::*; (
  alu_if.alu alu
);

  logic [4:0] shamt;

  assign shamt = alu.b[4:0];

  // flags are always valid, for branches and set-less-than
  assign alu.eq  = (alu.a == alu.b);
  assign alu.lt  = ($signed(alu.a) < $signed(alu.b));
  assign alu.ltu = (alu.a < alu.b);

  always_comb begin
    case (alu.op)
      alu_sub:  alu.result = alu.a - alu.b;
      alu_sll:  alu.result = alu.a << shamt;
      alu_slt:  alu.result = {{(xlen_lp-1){1'b0}}, alu.lt};
      alu_sltu: alu.result = {{(xlen_lp-1){1'b0}}, alu.ltu};
      alu_xor:  alu.result = alu.a ^ alu.b;
      alu_srl:  alu.result = alu.a >> shamt;
      alu_sra:  alu.result = $signed(alu.a) >>> shamt;
      alu_or:   alu.result = alu.a | alu.b;
      alu_and:  alu.result = alu.a & alu.b;
      default:  alu.result = alu.a + alu.b;
    endcase
  end

endmodule

// ==== hdl/rv32_core.sv ====
module rv32_core import rv32_pkg::*; (
  input  logic                clk_i,
  input  logic                reset_i,
  output logic [xlen_lp-1:0]  mem_addr_o,
  input  logic [bus_w_lp-1:0] mem_rdata_i,
  output logic [bus_w_lp-1:0] mem_wdata_o,
  output logic                mem_we_o,
  output logic                halt_o
);

  logic [ucode_aw_lp-1:0] ucode_addr;
  ctrl_word_t             ctrl_word;

  reg_if u_reg_if ();
  alu_if u_alu_if ();

  rv32_control u_rv32_control (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .mem_addr_o   (mem_addr_o),
    .mem_rdata_i  (mem_rdata_i),
    .mem_wdata_o  (mem_wdata_o),
    .mem_we_o     (mem_we_o),
    .halt_o       (halt_o),
    .ucode_addr_o (ucode_addr),
    .ctrl_i       (ctrl_word),
    .regs         (u_reg_if.ctrl),
    .alu          (u_alu_if.ctrl)
  );

  // control word is looked up in the same cycle
  rv32_microcode u_rv32_microcode (
    .ucode_addr_i (ucode_addr),
    .ctrl_o       (ctrl_word)
  );

  rv32_regfile u_rv32_regfile (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .regs    (u_reg_if.regs)
  );

  rv32_alu u_rv32_alu (
    .alu (u_alu_if.alu)
  );

endmodule

// ==== tests/rv32_core_asserts.sv ====
module rv32_core_asserts import rv32_pkg::*; (
  input logic                   clk_i,
  input logic                   reset_i,
  input logic [xlen_lp-1:0]     mem_addr_d,
  input logic                   mem_we_o,
  input logic                   halt_o,
  input logic [ucode_aw_lp-1:0] step_q,
  input logic [reg_aw_lp-1:0]   rs1_addr,
  input logic [reg_aw_lp-1:0]   rs2_addr,
  input logic [xlen_lp-1:0]     rs1_data,
  input logic [xlen_lp-1:0]     rs2_data
);
  timeunit 1ns;
  timeprecision 100ps;

  // the bus is halfword wide, so computed addresses stay even
  addr_even: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_addr_d[0] == 1'b0)
    else $error("memory address is odd");

  no_write_in_fetch: assert property (@(posedge clk_i) disable iff (reset_i)
    step_q < fetch_steps_lp |-> !mem_we_o)
    else $error("memory write during a fetch step");

  // only reset clears the halt level
  halt_sticky: assert property (@(posedge clk_i) disable iff (reset_i)
    halt_o |=> halt_o)
    else $error("halt_o fell without reset");

  // x0 stays zero even when an instruction names it as rd
  x0_reads_zero: assert property (@(posedge clk_i) disable iff (reset_i)
    (rs1_addr != 5'd0 || rs1_data == '0) && (rs2_addr != 5'd0 || rs2_data == '0))
    else $error("register x0 read back nonzero");

endmodule

bind rv32_control rv32_core_asserts u_rv32_core_asserts (
  .clk_i      (clk_i),
  .reset_i    (reset_i),
  .mem_addr_d (mem_addr_d),
  .mem_we_o   (mem_we_o),
  .halt_o     (halt_o),
  .step_q     (step_q),
  .rs1_addr   (regs.rs1_addr),
  .rs2_addr   (regs.rs2_addr),
  .rs1_data   (regs.rs1_data),
  .rs2_data   (regs.rs2_data)
);

// ==== tests/rv32_core_tb.sv ====
module rv32_core_tb import rv32_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  logic        clk_i;
  logic        reset_i;
  logic [31:0] mem_addr;
  logic [15:0] mem_rdata;
  logic [15:0] mem_wdata;
  logic        mem_we;
  logic        halt;

  logic [15:0] mem [0:32767];
  logic [15:0] iss_mem [0:32767];
  logic [31:0] exp_addr [$];
  logic [15:0] exp_data [$];
  int          exp_cycles;
  int          wr_idx;
  int          errors;
  int          pass_cnt;
  int          fail_cnt;
  logic        cmp_en;
  logic        wr_pend;
  logic [31:0] wr_a;
  logic [15:0] wr_d;
  logic [31:0] wp;

  rv32_core u_rv32_core (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .mem_addr_o  (mem_addr),
    .mem_rdata_i (mem_rdata),
    .mem_wdata_o (mem_wdata),
    .mem_we_o    (mem_we),
    .halt_o      (halt)
  );

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  // zero-wait-state memory, combinational read
  assign mem_rdata = mem[mem_addr[15:1]];

  // writes are sampled mid-cycle and compared in order
  always @(negedge clk_i) begin
    wr_pend = mem_we;
    if (mem_we) begin
      wr_a = mem_addr;
      wr_d = mem_wdata;
      if (cmp_en) begin
        assert (wr_idx < exp_addr.size() && exp_addr[wr_idx] == wr_a &&
                exp_data[wr_idx] == wr_d)
        else begin
          errors++;
          $display("FAILED %0t: write %0d addr %h data %h not expected", $time, wr_idx,
                   wr_a, wr_d);
        end
      end
      wr_idx++;
    end
  end

  always @(posedge clk_i) begin
    #2;
    if (wr_pend) mem[wr_a[15:1]] = wr_d;
  end

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2, rs1);
    return {imm[11:5], rs2, rs1, 3'd2, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                                        input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                         input logic [31:0] a, b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'b0, $signed(a) < $signed(b)};
      3'd3: return {31'b0, a < b};
      3'd4: return a ^ b;
      3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a, b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      3'd7: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // instruction-set model over iss_mem, records halfword stores and cycles
  function automatic void run_iss();
    logic [31:0] x [0:31];
    logic [31:0] pc, ins, a, b, r, nxt, addr, immi, imms;
    logic [14:0] idx;
    logic        wr;
    logic [2:0]  f3;
    for (int i = 0; i < 32; i++) x[i] = '0;
    pc = reset_vector_lp;
    exp_addr.delete();
    exp_data.delete();
    exp_cycles = 0;
    for (int n = 0; n < 4000; n++) begin
      idx = pc[15:1];
      ins = {iss_mem[idx + 15'd1], iss_mem[idx]};
      a = x[ins[19:15]];
      b = x[ins[24:20]];
      f3 = ins[14:12];
      immi = {{20{ins[31]}}, ins[31:20]};
      imms = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      nxt = pc + 4;
      wr = 1'b1;
      r = '0;
      exp_cycles += 3;
      case (ins[6:0])
        7'h33: r = alu_ref(f3, ins[30], a, b);
        7'h13: r = alu_ref(f3, f3 == 3'd5 && ins[30], a, immi);
        7'h37: r = {ins[31:12], 12'b0};
        7'h17: r = pc + {ins[31:12], 12'b0};
        7'h6f: begin
          r = pc + 4;
          nxt = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        end
        7'h67: begin
          r = pc + 4;
          nxt = (a + immi) & ~32'd1;
        end
        7'h63: begin
          wr = 1'b0;
          if (branch_ref(f3, a, b))
            nxt = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        end
        7'h03: begin
          addr = a + immi;
          idx = addr[15:1];
          r = {iss_mem[idx + 15'd1], iss_mem[idx]};
          exp_cycles += 1;
        end
        7'h23: begin
          addr = a + imms;
          idx = addr[15:1];
          iss_mem[idx] = b[15:0];
          iss_mem[idx + 15'd1] = b[31:16];
          exp_addr.push_back({addr[31:1], 1'b0});
          exp_data.push_back(b[15:0]);
          exp_addr.push_back({addr[31:1], 1'b0} + 32'd2);
          exp_data.push_back(b[31:16]);
          wr = 1'b0;
          exp_cycles += 1;
        end
        7'h73: return;
        default: wr = 1'b0;
      endcase
      if (wr && ins[11:7] != 5'd0) x[ins[11:7]] = r;
      pc = nxt;
    end
  endfunction

  task automatic emit_word(input logic [31:0] w);
    logic [14:0] wi;
    wi = wp[15:1];
    mem[wi] = w[15:0];
    mem[wi + 15'd1] = w[31:16];
    wp += 4;
  endtask

  task automatic clear_mem();
    for (int i = 0; i < 32768; i++) mem[i] = 16'(i * 2) ^ 16'h3c5a;
    wp = reset_vector_lp;
  endtask

  task automatic apply_reset();
    @(posedge clk_i);
    #2 reset_i = 1'b1;
    repeat (16) @(posedge clk_i);
    #2 reset_i = 1'b0;
  endtask

  task automatic check_value(input string what, input int got, input int exp);
    assert (got == exp)
    else begin
      errors++;
      $display("FAILED %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // runs the loaded program, optionally interrupted by a reset part way
  task automatic run_prog(input string name, input int cut_cycles);
    int cyc;
    int err0;
    int wr_done;
    err0 = errors;
    for (int i = 0; i < 32768; i++) iss_mem[i] = mem[i];
    run_iss();
    if (cut_cycles > 0) begin
      cmp_en = 1'b0;
      apply_reset();
      repeat (cut_cycles) @(posedge clk_i);
    end
    apply_reset();
    wr_idx = 0;
    cmp_en = 1'b1;
    cyc = 0;
    while (halt !== 1'b1 && cyc < 5000) begin
      @(posedge clk_i);
      #1 cyc++;
    end
    if (halt !== 1'b1) begin
      errors++;
      $display("timeout: halt_o never rose in test %s", name);
    end
    check_value("cycles to halt", cyc, exp_cycles);
    check_value("halfword writes", wr_idx, exp_addr.size());
    wr_done = wr_idx;
    repeat (10) @(posedge clk_i);
    check_value("writes after halt", wr_idx, wr_done);
    check_value("halt_o held", int'(halt === 1'b1), 1);
    if (errors == err0) begin
      pass_cnt++;
      $display("test %s: passed", name);
    end else begin
      fail_cnt++;
      $display("test %s: failed", name);
    end
  endtask

  task automatic build_random_alu();
    logic [2:0] f3;
    logic       alt;
    logic [11:0] imm;
    clear_mem();
    emit_word(u_type(20'h4, 5'd10, 7'h37));
    for (int k = 0; k < 16; k++) begin
      emit_word(u_type(20'($urandom), 5'd1, 7'h37));
      emit_word(i_type(12'($urandom), 5'd1, 3'd0, 5'd1, 7'h13));
      emit_word(u_type(20'($urandom), 5'd2, 7'h37));
      emit_word(i_type(12'($urandom), 5'd2, 3'd0, 5'd2, 7'h13));
      f3 = 3'($urandom);
      alt = 1'($urandom);
      if ($urandom % 2) begin
        emit_word(r_type((alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                         5'd2, 5'd1, f3, 5'd3));
      end else begin
        imm = 12'($urandom);
        if (f3 == 3'd1) imm = {7'h00, imm[4:0]};
        if (f3 == 3'd5) imm = {alt ? 7'h20 : 7'h00, imm[4:0]};
        emit_word(i_type(imm, 5'd1, f3, 5'd3, 7'h13));
      end
      emit_word(s_type(12'(4 * k), 5'd3, 5'd10));
    end
    emit_word(32'h0010_0073);
  endtask

  task automatic build_jumps();
    clear_mem();
    emit_word(u_type(20'h4, 5'd10, 7'h37));
    emit_word(u_type(20'($urandom), 5'd5, 7'h37));
    emit_word(s_type(12'd0, 5'd5, 5'd10));
    emit_word(u_type(20'($urandom), 5'd6, 7'h17));
    emit_word(s_type(12'd4, 5'd6, 5'd10));
    emit_word(j_type(21'd8, 5'd7));
    // skipped by the jump above
    emit_word(s_type(12'd8, 5'd5, 5'd10));
    emit_word(s_type(12'd12, 5'd7, 5'd10));
    emit_word(j_type(21'd20, 5'd1));
    emit_word(s_type(12'd16, 5'd8, 5'd10));
    emit_word(s_type(12'd20, 5'd9, 5'd10));
    emit_word(32'h0000_000f);
    emit_word(32'h0010_0073);
    emit_word(i_type(12'h123, 5'd0, 3'd0, 5'd8, 7'h13));
    emit_word(i_type(12'd0, 5'd1, 3'd0, 5'd9, 7'h67));
  endtask

  task automatic build_branches();
    logic [2:0] conds [6];
    logic [4:0] ra [4];
    logic [4:0] rb [4];
    int k;
    conds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    ra = '{5'd1, 5'd1, 5'd2, 5'd4};
    rb = '{5'd2, 5'd3, 5'd1, 5'd2};
    clear_mem();
    emit_word(u_type(20'h4, 5'd10, 7'h37));
    emit_word(u_type(20'h80000, 5'd1, 7'h37));
    emit_word(i_type(12'd1, 5'd0, 3'd0, 5'd2, 7'h13));
    emit_word(u_type(20'h80000, 5'd3, 7'h37));
    emit_word(i_type(12'hfff, 5'd0, 3'd0, 5'd4, 7'h13));
    k = 0;
    foreach (conds[c]) begin
      for (int p = 0; p < 4; p++) begin
        emit_word(b_type(13'd8, rb[p], ra[p], conds[c]));
        emit_word(s_type(12'(8 * k), 5'd2, 5'd10));
        emit_word(s_type(12'(8 * k + 4), 5'd1, 5'd10));
        k++;
      end
    end
    emit_word(32'h0010_0073);
  endtask

  task automatic build_load_store();
    clear_mem();
    emit_word(u_type(20'h4, 5'd10, 7'h37));
    emit_word(u_type(20'($urandom), 5'd1, 7'h37));
    emit_word(i_type(12'($urandom), 5'd1, 3'd0, 5'd1, 7'h13));
    emit_word(s_type(12'hffc, 5'd1, 5'd10));
    emit_word(i_type(12'hffc, 5'd10, 3'd2, 5'd2, 7'h03));
    emit_word(s_type(12'd0, 5'd2, 5'd10));
    emit_word(i_type(12'd64, 5'd10, 3'd0, 5'd11, 7'h13));
    emit_word(u_type(20'($urandom), 5'd5, 7'h37));
    emit_word(s_type(12'hff8, 5'd5, 5'd11));
    emit_word(i_type(12'hff8, 5'd11, 3'd2, 5'd6, 7'h03));
    emit_word(s_type(12'd4, 5'd6, 5'd10));
    // a write aimed at x0 must leave it zero
    emit_word(u_type(20'($urandom), 5'd0, 7'h37));
    emit_word(s_type(12'd8, 5'd0, 5'd10));
    emit_word(32'h0010_0073);
  endtask

  initial begin
    reset_i = 1'b1;
    cmp_en = 1'b0;
    wr_pend = 1'b0;
    wr_idx = 0;
    errors = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    void'($urandom(32'h6591_a2da));
    clear_mem();
    build_random_alu();
    run_prog("random_alu", 0);
    build_jumps();
    run_prog("upper_and_jumps", 0);
    build_branches();
    run_prog("branches", 0);
    build_load_store();
    run_prog("load_store", 0);
    build_jumps();
    run_prog("halt_and_restart", 23);
    $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module rv32_core_tb -f filelist.f -o rv32_sim

./obj_dir/rv32_sim | tee sim.log

if grep -q "=== PASS ===" sim.log; then
  exit 0
else
  exit 1
fi

// ==== filelist.f ====
hdl/rv32_pkg.sv
hdl/rv32_if.sv
hdl/rv32_microcode.sv
hdl/rv32_control.sv
hdl/rv32_regfile.sv
hdl/rv32_alu.sv
hdl/rv32_core.sv
tests/rv32_core_asserts.sv
tests/rv32_core_tb.sv
